/* build.f */
+incdir+src
src/cnn_pkg.sv
src/sram_pkg.sv
src/kernel_loader.sv
src/conv_sequencer.sv
src/conv_datapath.sv
src/pool_writer.sv
src/conv_pool_top.sv
tests/conv_pool_assertions.sv
tests/conv_pool_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the convolution engine testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module conv_pool_tb -o conv_pool_sim \
  && ./obj_dir/conv_pool_sim +verilator+error+limit+100 | tee sim.log \
  || echo "build or simulation did not complete"

grep -q "^STATUS: PASS$" sim.log && echo "run passed" && exit 0 \
  || { echo "run failed"; exit 1; }

/* src/cnn_config.svh */
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// --------------------
// data widths
// --------------------
`define CNN_PIXEL_W       8    // pixel and kernel byte
`define CNN_WORD_W        16   // one SRAM word, two pixels
`define CNN_ADDR_W        12
`define CNN_ACC_W         20   // nine 16 bit products plus headroom

// --------------------
// sizes
// --------------------
`define CNN_KERNEL_TAPS   9    // 3x3 kernel, row-major
`define CNN_NUM_ACC       4    // 2x2 outputs per window group

// five data words plus one cycle of read latency
`define CNN_KERNEL_READS  6

// --------------------
// limits
// --------------------
`define CNN_POOL_MAX      127  // clamp ceiling after relu

// end of the image list in the input SRAM
`define CNN_END_MARKER    {`CNN_WORD_W{1'b1}}

`endif

/* src/cnn_pkg.sv */
`include "cnn_config.svh"

package cnn_pkg;

  // --------------------
  // arithmetic types
  // --------------------

  // one signed pixel or kernel byte
  typedef logic signed [`CNN_PIXEL_W-1:0] pixel_t;

  // pixel times kernel byte
  typedef logic signed [2*`CNN_PIXEL_W-1:0] product_t;

  // running sum of one 3x3 window
  typedef logic signed [`CNN_ACC_W-1:0] acc_t;

  // --------------------
  // controller states
  // --------------------
  typedef enum logic [2:0] {
    st_idle,         // waiting for dut_run
    st_load_kernel,  // weights SRAM reads
    st_read_n,       // image header or end marker
    st_row0,         // four input rows per column step
    st_row1,
    st_row2,
    st_row3
  } conv_state_e;

endpackage

/* src/conv_datapath.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module conv_datapath (
  input  logic                 clk,
  input  logic                 reset_b,
  input  sram_pkg::sram_word_t input_sram_read_data,
  input  cnn_pkg::pixel_t      kernel [`CNN_KERNEL_TAPS],
  input  logic [1:0]           row_sel,
  input  logic                 capture,
  input  logic [3:0]           acc_en,
  input  logic                 acc_clear,
  input  logic                 pool_go,
  input  logic                 end_image_next,
  output cnn_pkg::acc_t        acc [`CNN_NUM_ACC],
  output logic                 pool_valid,
  output logic                 end_image
);

  cnn_pkg::pixel_t  row_buf [4][2];  // previous word of rows 0..3
  cnn_pkg::pixel_t  pix_hi, pix_lo;
  cnn_pkg::pixel_t  k_op [`CNN_NUM_ACC][3];
  cnn_pkg::pixel_t  p_op [`CNN_NUM_ACC][3];
  cnn_pkg::product_t prod [`CNN_NUM_ACC][3];
  cnn_pkg::acc_t    sum [`CNN_NUM_ACC];
  logic [1:0] top_row, bot_row;

  assign pix_hi = cnn_pkg::pixel_t'(input_sram_read_data[15:8]);
  assign pix_lo = cnn_pkg::pixel_t'(input_sram_read_data[7:0]);

  // top outputs see kernel row r, bottom outputs kernel row r-1
  assign top_row = (row_sel == 2'd3) ? 2'd2 : row_sel;
  assign bot_row = (row_sel == 2'd0) ? 2'd0 : row_sel - 2'd1;

  always_ff @(posedge clk) begin
    if (capture) begin
      row_buf[row_sel][0] <= pix_hi;
      row_buf[row_sel][1] <= pix_lo;
    end
  end

  // --------------------
  // operand routing
  // --------------------
  always_comb begin
    for (int t = 0; t < 3; t++) begin
      k_op[0][t] = kernel[top_row*3 + t];
      k_op[1][t] = kernel[top_row*3 + t];
      k_op[2][t] = kernel[bot_row*3 + t];
      k_op[3][t] = kernel[bot_row*3 + t];
    end
    // left column of the pair: buf0 buf1 hi
    p_op[0][0] = row_buf[row_sel][0];
    p_op[0][1] = row_buf[row_sel][1];
    p_op[0][2] = pix_hi;
    // right column: buf1 hi lo
    p_op[1][0] = row_buf[row_sel][1];
    p_op[1][1] = pix_hi;
    p_op[1][2] = pix_lo;
    for (int t = 0; t < 3; t++) begin
      p_op[2][t] = p_op[0][t];
      p_op[3][t] = p_op[1][t];
    end
  end

  // twelve multipliers, summed in threes
  for (genvar a = 0; a < `CNN_NUM_ACC; a++) begin : g_acc
    for (genvar t = 0; t < 3; t++) begin : g_tap
      assign prod[a][t] = k_op[a][t] * p_op[a][t];
    end
    assign sum[a] = cnn_pkg::acc_t'(prod[a][0]) + cnn_pkg::acc_t'(prod[a][1])
                  + cnn_pkg::acc_t'(prod[a][2]);
  end

  always_ff @(posedge clk) begin
    for (int a = 0; a < `CNN_NUM_ACC; a++) begin
      if (acc_en[a]) begin
        acc[a] <= acc_clear ? sum[a] : acc[a] + sum[a];
      end else if (acc_clear) begin
        acc[a] <= '0;
      end
    end
  end

  // lines up with the final sums
  always_ff @(posedge clk) begin
    if (reset_b) begin
      pool_valid <= 1'b0;
      end_image  <= 1'b0;
    end else begin
      pool_valid <= pool_go;
      end_image  <= end_image_next;
    end
  end

endmodule

/* src/conv_pool_top.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module conv_pool_top (
  input  logic                 clk,
  input  logic                 reset_b,
  input  logic                 dut_run,
  output logic                 dut_busy,
  output sram_pkg::sram_addr_t input_sram_read_address,
  input  sram_pkg::sram_word_t input_sram_read_data,
  output sram_pkg::sram_addr_t weights_sram_read_address,
  input  sram_pkg::sram_word_t weights_sram_read_data,
  output logic                 output_sram_write_enable,
  output sram_pkg::sram_addr_t output_sram_write_addresss,
  output sram_pkg::sram_word_t output_sram_write_data
);

  // --------------------
  // control
  // --------------------
  logic       load_k;
  logic       kernel_done;
  logic [1:0] row_sel;
  logic       capture;
  logic [3:0] acc_en;
  logic       acc_clear;
  logic       pool_go;
  logic       end_image_next;

  // --------------------
  // data
  // --------------------
  cnn_pkg::pixel_t kernel [`CNN_KERNEL_TAPS];
  cnn_pkg::acc_t   acc [`CNN_NUM_ACC];
  logic            pool_valid;
  logic            end_image;

  // last weights read is out, its data arrives next cycle
  assign kernel_done = (weights_sram_read_address ==
                        sram_pkg::sram_addr_t'(`CNN_KERNEL_READS - 1));

  conv_sequencer conv_sequencer_inst (
    .clk                     (clk),
    .reset_b                 (reset_b),
    .dut_run                 (dut_run),
    .input_sram_read_data    (input_sram_read_data),
    .kernel_done             (kernel_done),
    .dut_busy                (dut_busy),
    .input_sram_read_address (input_sram_read_address),
    .load_k                  (load_k),
    .row_sel                 (row_sel),
    .capture                 (capture),
    .acc_en                  (acc_en),
    .acc_clear               (acc_clear),
    .pool_go                 (pool_go),
    .end_image_next          (end_image_next)
  );

  kernel_loader kernel_loader_inst (
    .clk                       (clk),
    .reset_b                   (reset_b),
    .load_k                    (load_k),
    .weights_sram_read_data    (weights_sram_read_data),
    .weights_sram_read_address (weights_sram_read_address),
    .kernel                    (kernel)
  );

  conv_datapath conv_datapath_inst (
    .clk                  (clk),
    .reset_b              (reset_b),
    .input_sram_read_data (input_sram_read_data),
    .kernel               (kernel),
    .row_sel              (row_sel),
    .capture              (capture),
    .acc_en               (acc_en),
    .acc_clear            (acc_clear),
    .pool_go              (pool_go),
    .end_image_next       (end_image_next),
    .acc                  (acc),
    .pool_valid           (pool_valid),
    .end_image            (end_image)
  );

  pool_writer pool_writer_inst (
    .clk                        (clk),
    .reset_b                    (reset_b),
    .acc                        (acc),
    .pool_valid                 (pool_valid),
    .end_image                  (end_image),
    .output_sram_write_enable   (output_sram_write_enable),
    .output_sram_write_addresss (output_sram_write_addresss),
    .output_sram_write_data     (output_sram_write_data)
  );

endmodule

/* src/conv_sequencer.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module conv_sequencer (
  input  logic                 clk,
  input  logic                 reset_b,
  input  logic                 dut_run,
  input  sram_pkg::sram_word_t input_sram_read_data,
  input  logic                 kernel_done,
  output logic                 dut_busy,
  output sram_pkg::sram_addr_t input_sram_read_address,
  output logic                 load_k,
  output logic [1:0]           row_sel,
  output logic                 capture,
  output logic [3:0]           acc_en,
  output logic                 acc_clear,
  output logic                 pool_go,
  output logic                 end_image_next
);

  cnn_pkg::conv_state_e state, state_next;

  sram_pkg::sram_addr_t origin, origin_next;  // row0 word of the current step
  sram_pkg::sram_addr_t half_n_a, full_n_a;
  logic [`CNN_PIXEL_W-1:0] n_reg, n_next;
  logic [`CNN_PIXEL_W-1:0] col, col_next;     // word column, 1..N/2
  logic [`CNN_PIXEL_W-1:0] row, row_next;     // window row group, 1..N/2-1
  logic [`CNN_PIXEL_W-1:0] half_n;
  logic computing;
  logic col_last;
  logic row_last;
  logic list_end;

  assign half_n   = n_reg >> 1;
  assign half_n_a = sram_pkg::sram_addr_t'(half_n);
  assign full_n_a = sram_pkg::sram_addr_t'(n_reg);

  assign computing = (col != `CNN_PIXEL_W'(1));  // first column only fills the buffer
  assign col_last  = (col == half_n);
  assign row_last  = (row == half_n - `CNN_PIXEL_W'(1));
  assign list_end  = (input_sram_read_data == `CNN_END_MARKER);

  assign dut_busy = (state != cnn_pkg::st_idle);

  always_ff @(posedge clk) begin
    if (reset_b) begin
      state  <= cnn_pkg::st_idle;
      origin <= '0;
      n_reg  <= '0;
      col    <= `CNN_PIXEL_W'(1);
      row    <= `CNN_PIXEL_W'(1);
    end else begin
      state  <= state_next;
      origin <= origin_next;
      n_reg  <= n_next;
      col    <= col_next;
      row    <= row_next;
    end
  end

  // --------------------
  // next state and read address
  // --------------------
  always_comb begin
    state_next              = state;
    origin_next             = origin;
    n_next                  = n_reg;
    col_next                = col;
    row_next                = row;
    input_sram_read_address = origin;
    load_k                  = 1'b0;
    row_sel                 = 2'd0;
    capture                 = 1'b0;
    acc_en                  = 4'b0000;
    acc_clear               = 1'b0;
    pool_go                 = 1'b0;
    end_image_next          = 1'b0;

    case (state)
      cnn_pkg::st_idle: begin
        origin_next             = '0;
        input_sram_read_address = '0;  // header of the first image
        if (dut_run) state_next = cnn_pkg::st_load_kernel;
      end
      cnn_pkg::st_load_kernel: begin
        load_k = 1'b1;
        if (kernel_done) state_next = cnn_pkg::st_read_n;
      end
      cnn_pkg::st_read_n: begin
        if (list_end) begin
          origin_next             = '0;
          input_sram_read_address = '0;
          end_image_next          = 1'b1;  // also rewinds the output address
          state_next              = cnn_pkg::st_idle;
        end else begin
          n_next                  = input_sram_read_data[`CNN_PIXEL_W-1:0];
          origin_next             = origin + `CNN_ADDR_W'(1);
          input_sram_read_address = origin + `CNN_ADDR_W'(1);
          col_next                = `CNN_PIXEL_W'(1);
          row_next                = `CNN_PIXEL_W'(1);
          state_next              = cnn_pkg::st_row0;
        end
      end
      cnn_pkg::st_row0: begin
        input_sram_read_address = origin + half_n_a;  // row1
        row_sel    = 2'd0;
        capture    = 1'b1;
        acc_clear  = 1'b1;
        acc_en     = computing ? 4'b0011 : 4'b0000;
        state_next = cnn_pkg::st_row1;
      end
      cnn_pkg::st_row1: begin
        input_sram_read_address = origin + full_n_a;  // row2
        row_sel    = 2'd1;
        capture    = 1'b1;
        acc_en     = computing ? 4'b1111 : 4'b0000;
        state_next = cnn_pkg::st_row2;
      end
      cnn_pkg::st_row2: begin
        input_sram_read_address = origin + full_n_a + half_n_a;  // row3
        row_sel    = 2'd2;
        capture    = 1'b1;
        acc_en     = computing ? 4'b1111 : 4'b0000;
        state_next = cnn_pkg::st_row3;
      end
      cnn_pkg::st_row3: begin
        row_sel = 2'd3;
        capture = 1'b1;
        acc_en  = computing ? 4'b1100 : 4'b0000;
        pool_go = computing;
        if (!col_last) begin
          origin_next = origin + `CNN_ADDR_W'(1);
          col_next    = col + `CNN_PIXEL_W'(1);
          state_next  = cnn_pkg::st_row0;
        end else if (!row_last) begin
          // skip down two input rows
          origin_next = origin + half_n_a + `CNN_ADDR_W'(1);
          col_next    = `CNN_PIXEL_W'(1);
          row_next    = row + `CNN_PIXEL_W'(1);
          state_next  = cnn_pkg::st_row0;
        end else begin
          // next image header
          origin_next    = origin + full_n_a + half_n_a + `CNN_ADDR_W'(1);
          col_next       = `CNN_PIXEL_W'(1);
          row_next       = `CNN_PIXEL_W'(1);
          end_image_next = 1'b1;
          state_next     = cnn_pkg::st_read_n;
        end
        input_sram_read_address = origin_next;
      end
      default: state_next = cnn_pkg::st_idle;
    endcase
  end

endmodule

/* src/kernel_loader.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module kernel_loader (
  input  logic                 clk,
  input  logic                 reset_b,
  input  logic                 load_k,
  input  sram_pkg::sram_word_t weights_sram_read_data,
  output sram_pkg::sram_addr_t weights_sram_read_address,
  output cnn_pkg::pixel_t      kernel [`CNN_KERNEL_TAPS]
);

  // one spare byte at the tail, the low byte of the fifth word
  cnn_pkg::pixel_t chain [`CNN_KERNEL_TAPS+1];

  // address runs 0..5 while loading, parks at 0 otherwise
  always_ff @(posedge clk) begin
    if (reset_b) begin
      weights_sram_read_address <= '0;
    end else if (!load_k) begin
      weights_sram_read_address <= '0;
    end else if (weights_sram_read_address !=
                 sram_pkg::sram_addr_t'(`CNN_KERNEL_READS - 1)) begin
      weights_sram_read_address <= weights_sram_read_address + `CNN_ADDR_W'(1);
    end
  end

  // two bytes per cycle, oldest byte ends up in chain[0]
  always_ff @(posedge clk) begin
    if (load_k) begin
      for (int i = 0; i < `CNN_KERNEL_TAPS - 1; i++) begin
        chain[i] <= chain[i+2];
      end
      chain[`CNN_KERNEL_TAPS-1] <= cnn_pkg::pixel_t'(weights_sram_read_data[15:8]);
      chain[`CNN_KERNEL_TAPS]   <= cnn_pkg::pixel_t'(weights_sram_read_data[7:0]);
    end
  end

  always_comb begin
    for (int i = 0; i < `CNN_KERNEL_TAPS; i++) begin
      kernel[i] = chain[i];
    end
  end

endmodule

/* src/pool_writer.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module pool_writer (
  input  logic                 clk,
  input  logic                 reset_b,
  input  cnn_pkg::acc_t        acc [`CNN_NUM_ACC],
  input  logic                 pool_valid,
  input  logic                 end_image,
  output logic                 output_sram_write_enable,
  output sram_pkg::sram_addr_t output_sram_write_addresss,
  output sram_pkg::sram_word_t output_sram_write_data
);

  cnn_pkg::acc_t max_top, max_bot, max_all;
  logic [`CNN_PIXEL_W-1:0] pooled;
  sram_pkg::byte_lane_e lane;

  // --------------------
  // 2x2 max and clamp
  // --------------------
  assign max_top = (acc[0] >= acc[1]) ? acc[0] : acc[1];
  assign max_bot = (acc[2] >= acc[3]) ? acc[2] : acc[3];
  assign max_all = (max_top >= max_bot) ? max_top : max_bot;

  always_comb begin
    if (max_all <= cnn_pkg::acc_t'(0)) begin
      pooled = '0;  // relu
    end else if (max_all >= cnn_pkg::acc_t'(`CNN_POOL_MAX)) begin
      pooled = `CNN_PIXEL_W'(`CNN_POOL_MAX);
    end else begin
      pooled = max_all[`CNN_PIXEL_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset_b) begin
      output_sram_write_enable   <= 1'b0;
      output_sram_write_addresss <= '1;  // first increment lands on 0
      lane                       <= sram_pkg::lane_high;
    end else if (pool_valid) begin
      if (lane == sram_pkg::lane_high) begin
        output_sram_write_addresss <= output_sram_write_addresss + `CNN_ADDR_W'(1);
        output_sram_write_enable   <= end_image;  // odd count, flush now
        lane <= end_image ? sram_pkg::lane_high : sram_pkg::lane_low;
      end else begin
        output_sram_write_enable <= 1'b1;
        lane                     <= sram_pkg::lane_high;
      end
    end else begin
      output_sram_write_enable <= 1'b0;
      // end of list, next run starts over at address 0
      if (end_image) begin
        output_sram_write_addresss <= '1;
        lane                       <= sram_pkg::lane_high;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pool_valid) begin
      if (lane == sram_pkg::lane_high) begin
        output_sram_write_data[`CNN_WORD_W-1:`CNN_PIXEL_W] <= pooled;
        if (end_image) output_sram_write_data[`CNN_PIXEL_W-1:0] <= '0;  // pad byte
      end else begin
        output_sram_write_data[`CNN_PIXEL_W-1:0] <= pooled;
      end
    end
  end

endmodule

/* src/sram_pkg.sv */
`include "cnn_config.svh"

package sram_pkg;

  // --------------------
  // memory types
  // --------------------
  typedef logic [`CNN_ADDR_W-1:0] sram_addr_t;
  typedef logic [`CNN_WORD_W-1:0] sram_word_t;

  // which half of the output word a pooled byte goes to
  typedef enum logic {
    lane_high,  // first byte, bits 15:8
    lane_low    // second byte, completes the word
  } byte_lane_e;

endpackage

/* tests/conv_pool_assertions.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module conv_pool_assertions (
  input logic                 clk,
  input logic                 reset_b,
  input logic                 dut_run,
  input logic                 dut_busy,
  input logic                 output_sram_write_enable,
  input sram_pkg::sram_addr_t output_sram_write_addresss,
  input sram_pkg::sram_word_t output_sram_write_data
);

  int   failures = 0;  // read by the testbench at the end
  logic started;       // dut_run seen since reset

  always_ff @(posedge clk) begin
    if (reset_b) begin
      started <= 1'b0;
    end else if (dut_run) begin
      started <= 1'b1;
    end
  end

  // --------------------
  // start and idle
  // --------------------
  quiet_before_run: assert property (@(posedge clk) disable iff (reset_b)
    !started |-> !dut_busy && !output_sram_write_enable)
    else begin
      $error("busy or write enable high before the first dut_run");
      failures++;
    end

  busy_after_run: assert property (@(posedge clk) disable iff (reset_b)
    dut_run && !dut_busy |=> dut_busy)
    else begin
      $error("dut_busy did not rise after dut_run");
      failures++;
    end

  // one trailing write is allowed in the cycle after busy falls
  write_only_when_busy: assert property (@(posedge clk) disable iff (reset_b)
    output_sram_write_enable |-> dut_busy || $past(dut_busy))
    else begin
      $error("output write while the engine is idle");
      failures++;
    end

  // --------------------
  // output data and address
  // --------------------
  bytes_clamped: assert property (@(posedge clk) disable iff (reset_b)
    output_sram_write_enable |->
      output_sram_write_data[15:8] <= `CNN_PIXEL_W'(`CNN_POOL_MAX) &&
      output_sram_write_data[7:0]  <= `CNN_PIXEL_W'(`CNN_POOL_MAX))
    else begin
      $error("written byte above the clamp ceiling");
      failures++;
    end

  // all ones is the rewind at the end of the list
  address_steps_by_one: assert property (@(posedge clk) disable iff (reset_b)
    $changed(output_sram_write_addresss) |->
      output_sram_write_addresss == $past(output_sram_write_addresss) + `CNN_ADDR_W'(1) ||
      output_sram_write_addresss == '1)
    else begin
      $error("output write address jumped");
      failures++;
    end

endmodule

bind conv_pool_top conv_pool_assertions conv_pool_assertions_inst (
  .clk                        (clk),
  .reset_b                    (reset_b),
  .dut_run                    (dut_run),
  .dut_busy                   (dut_busy),
  .output_sram_write_enable   (output_sram_write_enable),
  .output_sram_write_addresss (output_sram_write_addresss),
  .output_sram_write_data     (output_sram_write_data)
);

/* tests/conv_pool_tb.sv */
`timescale 1ns/1ps
`include "cnn_config.svh"

module conv_pool_tb;

  logic                 clk;
  logic                 reset_b;
  logic                 dut_run;
  logic                 dut_busy;
  sram_pkg::sram_addr_t input_sram_read_address;
  sram_pkg::sram_word_t input_sram_read_data = '0;
  sram_pkg::sram_addr_t weights_sram_read_address;
  sram_pkg::sram_word_t weights_sram_read_data = '0;
  logic                 output_sram_write_enable;
  sram_pkg::sram_addr_t output_sram_write_addresss;
  sram_pkg::sram_word_t output_sram_write_data;

  sram_pkg::sram_word_t input_mem   [1 << `CNN_ADDR_W];
  sram_pkg::sram_word_t weights_mem [1 << `CNN_ADDR_W];
  sram_pkg::sram_word_t output_mem  [1 << `CNN_ADDR_W];
  sram_pkg::sram_word_t expected_words [$];

  int kern [`CNN_KERNEL_TAPS];  // row-major, signed
  int next_addr;
  int write_count = 0;
  int cycles = 0;
  int cycle_limit;
  int tests, failed_tests, errors, assert_failures;

  conv_pool_top conv_pool_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // SRAM models
  // --------------------
  always @(posedge clk) begin
    input_sram_read_data   <= input_mem[input_sram_read_address];
    weights_sram_read_data <= weights_mem[weights_sram_read_address];
    if (output_sram_write_enable) begin
      output_mem[output_sram_write_addresss] = output_sram_write_data;
      write_count++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the engine did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic sram_pkg::sram_word_t fill_word(input int a);
    return {4'hA, 12'(a)};  // high byte above any pooled byte
  endfunction

  function automatic int image_cycles(input int n);
    return 1 + 4 * (n / 2) * (n / 2 - 1);
  endfunction

  // --------------------
  // reference model
  // --------------------
  function automatic int pixel_at(input int base, input int n, input int r, input int c);
    sram_pkg::sram_word_t w;
    logic signed [7:0] b;
    w = input_mem[base + 1 + r * (n / 2) + c / 2];
    b = (c % 2 == 0) ? w[15:8] : w[7:0];  // high byte is the left pixel
    return int'(b);
  endfunction

  function automatic int conv_ref(input int base, input int n, input int r, input int c);
    int s;
    s = 0;
    for (int a = 0; a < 3; a++) begin
      for (int b = 0; b < 3; b++) begin
        s += kern[a * 3 + b] * pixel_at(base, n, r + a, c + b);
      end
    end
    return s;
  endfunction

  function automatic logic [7:0] pool_ref(input int base, input int n, input int i, input int j);
    int best;
    int s;
    best = conv_ref(base, n, 2 * i, 2 * j);
    for (int di = 0; di < 2; di++) begin
      for (int dj = 0; dj < 2; dj++) begin
        s = conv_ref(base, n, 2 * i + di, 2 * j + dj);
        if (s > best) best = s;
      end
    end
    if (best < 0) return 8'd0;  // relu
    if (best > `CNN_POOL_MAX) return 8'(`CNN_POOL_MAX);
    return 8'(best);
  endfunction

  // header, random or saturated pixels, then the expected packed words
  task automatic add_image(input int n, input bit saturate);
    int base;
    logic [7:0] bytes [$];
    base = next_addr;
    input_mem[next_addr] = {8'($urandom), 8'(n)};
    next_addr++;
    for (int w = 0; w < n * n / 2; w++) begin
      input_mem[next_addr] = saturate ? 16'h7F7F : 16'($urandom);
      next_addr++;
    end
    for (int i = 0; i < n / 2 - 1; i++) begin
      for (int j = 0; j < n / 2 - 1; j++) begin
        bytes.push_back(pool_ref(base, n, i, j));
      end
    end
    if (bytes.size() % 2 == 1) bytes.push_back(8'h00);  // pad byte
    for (int k = 0; k < bytes.size(); k += 2) begin
      expected_words.push_back({bytes[k], bytes[k + 1]});
    end
  endtask

  // kernel mode 0 random, 1 all 127, 2 negate the current kernel
  task automatic setup_run(input int kernel_mode, input bit saturate,
                           input int n_first, input int n_second);
    for (int t = 0; t < `CNN_KERNEL_TAPS; t++) begin
      case (kernel_mode)
        0: kern[t] = int'($signed(8'($urandom)));
        1: kern[t] = 127;
        default: kern[t] = -kern[t];
      endcase
    end
    for (int w = 0; w < 4; w++) begin
      weights_mem[w] = {8'(kern[2 * w]), 8'(kern[2 * w + 1])};
    end
    weights_mem[4] = {8'(kern[8]), 8'($urandom)};  // low byte unused
    next_addr = 0;
    expected_words.delete();
    add_image(n_first, saturate);
    if (n_second > 0) add_image(n_second, saturate);
    input_mem[next_addr] = `CNN_END_MARKER;
  endtask

  task automatic report_test(input string name, input int bad);
    tests++;
    errors += bad;
    if (bad > 0) failed_tests++;
    $display("test %0d %s: %s", tests, name, (bad == 0) ? "passed" : "failed");
  endtask

  task automatic check_idle(input int n_cycles);
    int bad;
    bad = 0;
    repeat (n_cycles) begin
      @(posedge clk);
      #2;
      assert (!dut_busy && !output_sram_write_enable) else begin
        $display("Error %0t: busy or write enable high before dut_run", $time);
        bad++;
      end
    end
    assert (write_count == 0) else begin
      $display("Error %0t: %0d output writes before dut_run", $time, write_count);
      bad++;
    end
    report_test("reset and idle", bad);
  endtask

  task automatic run_and_check(input string name);
    int bad;
    int last;
    bad = 0;
    for (int a = 0; a < (1 << `CNN_ADDR_W); a++) output_mem[a] = fill_word(a);
    dut_run = 1'b1;
    @(posedge clk);
    #2;
    dut_run = 1'b0;
    assert (dut_busy) else begin
      $display("Error %0t: dut_busy did not rise after dut_run", $time);
      bad++;
    end
    while (dut_busy) begin
      @(posedge clk);
      #2;
    end
    repeat (2) begin  // last write lands after busy falls
      @(posedge clk);
      #2;
    end
    for (int k = 0; k < expected_words.size(); k++) begin
      assert (output_mem[k] === expected_words[k]) else begin
        $display("Error %0t: %s word %0d is %h, expected %h",
                 $time, name, k, output_mem[k], expected_words[k]);
        bad++;
      end
    end
    last = expected_words.size();
    assert (output_mem[last] === fill_word(last)) else begin
      $display("Error %0t: %s wrote past the last word %0d", $time, name, last - 1);
      bad++;
    end
    report_test(name, bad);
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    void'($urandom(32'h2543));
    reset_b = 1'b1;
    dut_run = 1'b0;
    tests = 0;
    failed_tests = 0;
    errors = 0;
    // five runs with kernel load, marker and slack, plus reset and idle
    cycle_limit = 4 * (20 + 5 * 16 + 2 * image_cycles(6) + 3 * image_cycles(8)
                  + image_cycles(10)) + 200;
    repeat (5) @(posedge clk);
    #2;
    reset_b = 1'b0;

    check_idle(10);
    setup_run(0, 1'b0, 6, 0);
    run_and_check("single 6x6 image");
    setup_run(0, 1'b0, 8, 10);
    run_and_check("8x8 then 10x10 images");
    setup_run(1, 1'b1, 8, 0);
    run_and_check("saturation");
    setup_run(2, 1'b1, 8, 0);
    run_and_check("relu with negated kernel");
    setup_run(0, 1'b0, 6, 0);
    run_and_check("restart with new kernel");

    assert_failures = conv_pool_top_inst.conv_pool_assertions_inst.failures;
    $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
             tests, failed_tests, errors, assert_failures);
    if (failed_tests == 0 && assert_failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
